//--- gspAlu.sv
// Integer ALU with flag generation
`timescale 1ns/1ps

module gspAlu (
	input  logic [gspPkg::DataWidth-1:0] opA,
	input  logic [gspPkg::DataWidth-1:0] opB,
	input  gspPkg::opcode_t              op,
	output logic [gspPkg::DataWidth-1:0] aluResult,
	output logic                         aluN,
	output logic                         aluC,
	output logic                         aluZ,
	output logic                         aluV
);
	import gspPkg::*;

	localparam int Msb = DataWidth - 1;

	logic [DataWidth:0] sum;
	logic [DataWidth:0] diff;
	logic [DataWidth:0] shl;	// Carry in the top bit
	logic [DataWidth:0] shr;	// Carry in the bottom bit
	logic [DataWidth:0] sra;
	logic [4:0]         shAmt;

	assign shAmt = opB[4:0];
	assign sum   = {1'b0, opA} + {1'b0, opB};
	assign diff  = {1'b0, opA} - {1'b0, opB};	// Top bit is the borrow
	assign shl   = {1'b0, opA} << shAmt;
	assign shr   = {opA, 1'b0} >> shAmt;
	assign sra   = $unsigned($signed({opA, 1'b0}) >>> shAmt);

	always_comb begin
		aluResult = opA;
		aluC = 1'b0;
		aluV = 1'b0;
		case (op)
			OP_MOVI: aluResult = opB;
			OP_ADD: begin
				aluResult = sum[Msb:0];
				aluC = sum[DataWidth];
				aluV = (opA[Msb] == opB[Msb]) && (sum[Msb] != opA[Msb]);
			end
			OP_SUB: begin
				aluResult = diff[Msb:0];
				aluC = diff[DataWidth];
				aluV = (opA[Msb] != opB[Msb]) && (diff[Msb] != opA[Msb]);
			end
			OP_AND: aluResult = opA & opB;
			OP_OR:  aluResult = opA | opB;
			OP_XOR: aluResult = opA ^ opB;
			OP_SLL: begin
				aluResult = shl[Msb:0];
				aluC = shl[DataWidth];	// Last bit out of the top
			end
			OP_SRL: begin
				aluResult = shr[DataWidth:1];
				aluC = shr[0];
			end
			OP_SRA: begin
				aluResult = sra[DataWidth:1];
				aluC = sra[0];
			end
			default: ;	// Divide and jump pass opA
		endcase
		aluN = aluResult[Msb];
		aluZ = (aluResult == '0);
	end

endmodule

//--- gspDivider.sv
// Unsigned restoring divider
`timescale 1ns/1ps

module gspDivider (
	input  logic                         CLK,
	input  logic                         RST_N,
	input  logic                         divReq,
	input  logic [gspPkg::DataWidth-1:0] dividend,
	input  logic [gspPkg::DataWidth-1:0] divisor,
	output logic                         divAck,
	output logic [gspPkg::DataWidth-1:0] quotient,
	output logic                         divByZero
);
	import gspPkg::*;

	logic                         busy;
	logic [$clog2(DataWidth)-1:0] stepCnt;
	logic [DataWidth-1:0]         remQ;	// Partial remainder
	logic [DataWidth-1:0]         dvsQ;
	logic [DataWidth:0]           remShift;
	logic [DataWidth+1:0]         trial;
	logic                         borrow;
	logic                         start;

	assign start = divReq && !divAck && !busy;

	// Quotient register also shifts the dividend out from the top
	assign remShift = {remQ, quotient[DataWidth-1]};
	assign trial    = {1'b0, remShift} - {2'b00, dvsQ};
	assign borrow   = trial[DataWidth+1];

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			busy <= 1'b0;
			stepCnt <= '0;
			divAck <= 1'b0;
			divByZero <= 1'b0;
		end else if (start) begin
			divByZero <= (divisor == '0);
			divAck <= (divisor == '0);	// No steps for a zero divisor
			busy <= (divisor != '0);
			stepCnt <= '0;
		end else if (busy) begin
			stepCnt <= stepCnt + 1'b1;
			if (&stepCnt) begin
				busy <= 1'b0;
				divAck <= 1'b1;
			end
		end else if (divAck && !divReq) begin
			divAck <= 1'b0;
		end
	end

	always_ff @(posedge CLK) begin
		if (start) begin
			remQ <= '0;
			dvsQ <= divisor;
			quotient <= dividend;
		end else if (busy) begin
			remQ <= borrow ? remShift[DataWidth-1:0] : trial[DataWidth-1:0];
			quotient <= {quotient[DataWidth-2:0], ~borrow};
		end
	end

	// Ack must be released one cycle after the request drops
	assert property (@(posedge CLK) disable iff (!RST_N)
		(!divReq ##1 !divReq) |-> !divAck);

endmodule

//--- gspExec.f
gspPkg.sv
gspRegFile.sv
gspAlu.sv
gspDivider.sv
gspStatus.sv
gspSequencer.sv
gspExec.sv
tbGspExec.sv

//--- gspExec.sv
// GSP execution core top
`timescale 1ns/1ps

module gspExec #(
	parameter int NumRegs = 16
) (
	input  logic                         CLK,
	input  logic                         RST_N,
	input  logic                         cmdReq,
	input  gspPkg::opcode_t              cmdOp,
	input  logic [$clog2(NumRegs)-1:0]   cmdRd,
	input  logic [$clog2(NumRegs)-1:0]   cmdRs,
	input  logic [gspPkg::DataWidth-1:0] cmdImm,
	input  gspPkg::cond_t                cmdCond,
	output logic                         cmdAck,
	output logic [gspPkg::DataWidth-1:0] result,
	output logic                         flagN,
	output logic                         flagC,
	output logic                         flagZ,
	output logic                         flagV,
	output logic                         condTrue
);
	import gspPkg::*;

	localparam int AddrW = $clog2(NumRegs);

	logic [AddrW-1:0]     rdAddr;
	logic [AddrW-1:0]     rsAddr;
	logic [AddrW-1:0]     wrAddr;
	logic                 wrEn;
	logic [DataWidth-1:0] rdData;
	logic [DataWidth-1:0] rsData;
	logic [DataWidth-1:0] wrData;
	logic [DataWidth-1:0] opA;
	logic [DataWidth-1:0] opB;
	opcode_t              aluOp;
	logic [DataWidth-1:0] aluResult;
	logic                 aluN;
	logic                 aluC;
	logic                 aluZ;
	logic                 aluV;
	logic                 divReq;
	logic                 divAck;
	logic [DataWidth-1:0] dividend;
	logic [DataWidth-1:0] divisor;
	logic [DataWidth-1:0] quotient;
	logic                 divByZero;
	logic                 flagWr;
	logic                 updN;
	logic                 updC;
	logic                 updZ;
	logic                 updV;
	logic                 newN;
	logic                 newC;
	logic                 newZ;
	logic                 newV;

	gspSequencer #(.NumRegs(NumRegs)) i_seq (
		.CLK(CLK), .RST_N(RST_N),
		.cmdReq(cmdReq), .cmdOp(cmdOp), .cmdRd(cmdRd), .cmdRs(cmdRs), .cmdImm(cmdImm),
		.rdData(rdData), .rsData(rsData),
		.aluResult(aluResult), .aluN(aluN), .aluC(aluC), .aluZ(aluZ), .aluV(aluV),
		.divAck(divAck), .quotient(quotient), .divByZero(divByZero),
		.cmdAck(cmdAck), .result(result),
		.rdAddr(rdAddr), .rsAddr(rsAddr), .wrEn(wrEn), .wrAddr(wrAddr), .wrData(wrData),
		.opA(opA), .opB(opB), .aluOp(aluOp),
		.divReq(divReq), .dividend(dividend), .divisor(divisor),
		.flagWr(flagWr), .updN(updN), .updC(updC), .updZ(updZ), .updV(updV),
		.newN(newN), .newC(newC), .newZ(newZ), .newV(newV)
	);

	gspRegFile #(.NumRegs(NumRegs)) i_regs (
		.CLK(CLK), .RST_N(RST_N),
		.rdAddr(rdAddr), .rsAddr(rsAddr),
		.wrEn(wrEn), .wrAddr(wrAddr), .wrData(wrData),
		.rdData(rdData), .rsData(rsData)
	);

	gspAlu i_alu (
		.opA(opA), .opB(opB), .op(aluOp),
		.aluResult(aluResult), .aluN(aluN), .aluC(aluC), .aluZ(aluZ), .aluV(aluV)
	);

	gspDivider i_div (
		.CLK(CLK), .RST_N(RST_N),
		.divReq(divReq), .dividend(dividend), .divisor(divisor),
		.divAck(divAck), .quotient(quotient), .divByZero(divByZero)
	);

	gspStatus i_status (
		.CLK(CLK), .RST_N(RST_N),
		.flagWr(flagWr), .updN(updN), .updC(updC), .updZ(updZ), .updV(updV),
		.newN(newN), .newC(newC), .newZ(newZ), .newV(newV),
		.cond(cmdCond),
		.flagN(flagN), .flagC(flagC), .flagZ(flagZ), .flagV(flagV),
		.condTrue(condTrue)
	);

endmodule

//--- gspPkg.sv
// GSP execution core types
package gspPkg;

	localparam int DataWidth = 32;

	// Host command opcodes
	typedef enum logic [3:0] {
		OP_MOVI = 4'd0,
		OP_ADD  = 4'd1,
		OP_SUB  = 4'd2,
		OP_AND  = 4'd3,
		OP_OR   = 4'd4,
		OP_XOR  = 4'd5,
		OP_SLL  = 4'd6,
		OP_SRL  = 4'd7,
		OP_SRA  = 4'd8,
		OP_DIVU = 4'd9,
		OP_JCC  = 4'd10
	} opcode_t;

	// Jump conditions in jump field code order
	typedef enum logic [3:0] {
		UC = 4'h0,	// Unconditional
		P  = 4'h1,	// Positive
		LS = 4'h2,	// Lower or same
		HI = 4'h3,
		LT = 4'h4,
		GE = 4'h5,
		LE = 4'h6,
		GT = 4'h7,
		LO = 4'h8,	// Carry set
		HS = 4'h9,
		EQ = 4'hA,
		NE = 4'hB,
		V  = 4'hC,
		NV = 4'hD,
		N  = 4'hE,
		NN = 4'hF
	} cond_t;

	// Command sequencer states
	typedef enum logic [1:0] {
		S_IDLE = 2'd0,	// Waiting for cmdReq
		S_EXEC = 2'd1,	// Read and execute
		S_DIV  = 2'd2,	// Divider running
		S_ACK  = 2'd3	// Write back, then hold ack
	} seqState_t;

endpackage

//--- gspRegFile.sv
// General register file
`timescale 1ns/1ps

module gspRegFile #(
	parameter int NumRegs = 16
) (
	input  logic                         CLK,
	input  logic                         RST_N,
	input  logic [$clog2(NumRegs)-1:0]   rdAddr,
	input  logic [$clog2(NumRegs)-1:0]   rsAddr,
	input  logic                         wrEn,
	input  logic [$clog2(NumRegs)-1:0]   wrAddr,
	input  logic [gspPkg::DataWidth-1:0] wrData,
	output logic [gspPkg::DataWidth-1:0] rdData,
	output logic [gspPkg::DataWidth-1:0] rsData
);
	import gspPkg::*;

	logic [DataWidth-1:0] regs [NumRegs];

	assign rdData = regs[rdAddr];
	assign rsData = regs[rsAddr];

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			for (int i = 0; i < NumRegs; i++) begin
				regs[i] <= '0;
			end
		end else if (wrEn) begin
			regs[wrAddr] <= wrData;
		end
	end

	// Sequencer must only write existing registers
	assert property (@(posedge CLK) disable iff (!RST_N)
		wrEn |-> (int'(wrAddr) < NumRegs));

endmodule

//--- gspSequencer.sv
// Command handshake and sequencer
`timescale 1ns/1ps

module gspSequencer #(
	parameter int NumRegs = 16
) (
	input  logic                         CLK,
	input  logic                         RST_N,
	input  logic                         cmdReq,
	input  gspPkg::opcode_t              cmdOp,
	input  logic [$clog2(NumRegs)-1:0]   cmdRd,
	input  logic [$clog2(NumRegs)-1:0]   cmdRs,
	input  logic [gspPkg::DataWidth-1:0] cmdImm,
	input  logic [gspPkg::DataWidth-1:0] rdData,
	input  logic [gspPkg::DataWidth-1:0] rsData,
	input  logic [gspPkg::DataWidth-1:0] aluResult,
	input  logic                         aluN,
	input  logic                         aluC,
	input  logic                         aluZ,
	input  logic                         aluV,
	input  logic                         divAck,
	input  logic [gspPkg::DataWidth-1:0] quotient,
	input  logic                         divByZero,
	output logic                         cmdAck,
	output logic [gspPkg::DataWidth-1:0] result,
	output logic [$clog2(NumRegs)-1:0]   rdAddr,
	output logic [$clog2(NumRegs)-1:0]   rsAddr,
	output logic                         wrEn,
	output logic [$clog2(NumRegs)-1:0]   wrAddr,
	output logic [gspPkg::DataWidth-1:0] wrData,
	output logic [gspPkg::DataWidth-1:0] opA,
	output logic [gspPkg::DataWidth-1:0] opB,
	output gspPkg::opcode_t              aluOp,
	output logic                         divReq,
	output logic [gspPkg::DataWidth-1:0] dividend,
	output logic [gspPkg::DataWidth-1:0] divisor,
	output logic                         flagWr,
	output logic                         updN,
	output logic                         updC,
	output logic                         updZ,
	output logic                         updV,
	output logic                         newN,
	output logic                         newC,
	output logic                         newZ,
	output logic                         newV
);
	import gspPkg::*;

	localparam int AddrW = $clog2(NumRegs);

	seqState_t            state;
	opcode_t              opQ;
	logic [AddrW-1:0]     rdQ;
	logic [AddrW-1:0]     rsQ;
	logic [DataWidth-1:0] immQ;
	logic [DataWidth-1:0] resVal;	// Value of rd after the command
	logic                 accept;

	assign accept = cmdReq && !cmdAck;

	assign rdAddr = rdQ;
	assign rsAddr = rsQ;
	assign wrAddr = rdQ;
	assign opA    = rdData;
	assign opB    = (opQ == OP_MOVI) ? immQ : rsData;
	assign aluOp  = opQ;
	assign wrData = resVal;
	assign result = resVal;

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			state <= S_IDLE;
			cmdAck <= 1'b0;
			wrEn <= 1'b0;
			flagWr <= 1'b0;
			divReq <= 1'b0;
		end else begin
			case (state)
				S_IDLE: if (accept) state <= S_EXEC;
				S_EXEC: begin
					if (opQ == OP_DIVU) begin
						divReq <= 1'b1;
						state <= S_DIV;
					end else begin
						wrEn <= (opQ != OP_JCC);	// Jump only reads the flags
						flagWr <= (opQ != OP_JCC);
						state <= S_ACK;
					end
				end
				S_DIV: if (divAck) begin
					divReq <= 1'b0;
					wrEn <= !divByZero;
					flagWr <= 1'b1;
					state <= S_ACK;
				end
				S_ACK: begin
					wrEn <= 1'b0;
					flagWr <= 1'b0;
					if (!cmdAck) begin
						cmdAck <= 1'b1;
					end else if (!cmdReq) begin
						cmdAck <= 1'b0;
						state <= S_IDLE;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge CLK) begin
		case (state)
			S_IDLE: if (accept) begin
				opQ <= cmdOp;
				rdQ <= cmdRd;
				rsQ <= cmdRs;
				immQ <= cmdImm;
			end
			S_EXEC: begin
				resVal <= (opQ == OP_JCC) ? rdData : aluResult;
				dividend <= opA;
				divisor <= opB;
				{newN, newC, newZ, newV} <= {aluN, aluC, aluZ, aluV};
				case (opQ)
					OP_ADD, OP_SUB, OP_SLL, OP_SRL, OP_SRA: {updN, updC, updZ, updV} <= 4'b1111;
					OP_AND, OP_OR, OP_XOR: {updN, updC, updZ, updV} <= 4'b0011;
					OP_MOVI: {updN, updC, updZ, updV} <= 4'b1011;
					default: {updN, updC, updZ, updV} <= 4'b0000;
				endcase
			end
			S_DIV: if (divAck) begin
				resVal <= divByZero ? rdData : quotient;	// rd kept on zero divisor
				newN <= quotient[DataWidth-1];
				newC <= 1'b0;
				newZ <= (quotient == '0);
				newV <= divByZero;
				{updN, updC, updZ, updV} <= divByZero ? 4'b0001 : 4'b1011;
			end
			default: ;
		endcase
	end

	// Host keeps cmdReq up until it sees the ack
	assert property (@(posedge CLK) disable iff (!RST_N)
		(!cmdReq && !cmdAck) |=> !cmdAck);

endmodule

//--- gspStatus.sv
// Status flags and jump conditions
`timescale 1ns/1ps

module gspStatus (
	input  logic          CLK,
	input  logic          RST_N,
	input  logic          flagWr,
	input  logic          updN,
	input  logic          updC,
	input  logic          updZ,
	input  logic          updV,
	input  logic          newN,
	input  logic          newC,
	input  logic          newZ,
	input  logic          newV,
	input  gspPkg::cond_t cond,
	output logic          flagN,
	output logic          flagC,
	output logic          flagZ,
	output logic          flagV,
	output logic          condTrue
);
	import gspPkg::*;

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			flagN <= 1'b0;
			flagC <= 1'b0;
			flagZ <= 1'b0;
			flagV <= 1'b0;
		end else if (flagWr) begin
			if (updN) flagN <= newN;
			if (updC) flagC <= newC;
			if (updZ) flagZ <= newZ;
			if (updV) flagV <= newV;
		end
	end

	always_comb begin
		case (cond)
			UC: condTrue = 1'b1;
			P:  condTrue = !flagN && !flagZ;
			LS: condTrue = flagC || flagZ;
			HI: condTrue = !flagC && !flagZ;
			LT: condTrue = flagN ^ flagV;
			GE: condTrue = !(flagN ^ flagV);
			LE: condTrue = (flagN ^ flagV) || flagZ;
			GT: condTrue = !flagZ && !(flagN ^ flagV);
			LO: condTrue = flagC;
			HS: condTrue = !flagC;
			EQ: condTrue = flagZ;
			NE: condTrue = !flagZ;
			V:  condTrue = flagV;
			NV: condTrue = !flagV;
			N:  condTrue = flagN;
			NN: condTrue = !flagN;
			default: condTrue = 1'b0;
		endcase
	end

endmodule

//--- run.sh
#!/bin/sh
# Build and run the GSP execution core testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --top-module tbGspExec -f gspExec.f -o simGspExec
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/simGspExec > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "^Everything OK$" "$LOG"; then
	exit 0
fi
exit 1

//--- tbGspExec.sv
// GSP execution core testbench
`timescale 1ns/1ps

module tbGspExec;
	import gspPkg::*;

	localparam int NumDirected = 60;
	localparam int NumRandom = 300;
	localparam int WatchdogCycles = (NumDirected + NumRandom) * 50 + 100;

	logic        CLK;
	logic        RST_N;
	logic        cmdReq;
	opcode_t     cmdOp;
	logic [3:0]  cmdRd;
	logic [3:0]  cmdRs;
	logic [31:0] cmdImm;
	cond_t       cmdCond;
	logic        cmdAck;
	logic [31:0] result;
	logic        flagN;
	logic        flagC;
	logic        flagZ;
	logic        flagV;
	logic        condTrue;

	// Reference model state
	logic [31:0] model [16];
	logic        mN;
	logic        mC;
	logic        mZ;
	logic        mV;
	logic [31:0] expResult;
	logic        expN;
	logic        expC;
	logic        expZ;
	logic        expV;
	logic        expCond;
	int          valueErrs;
	int          protoErrs;
	int          cmdsDone;
	integer      seed;

	gspExec #(.NumRegs(16)) i_dut (
		.CLK(CLK), .RST_N(RST_N),
		.cmdReq(cmdReq), .cmdOp(cmdOp), .cmdRd(cmdRd), .cmdRs(cmdRs),
		.cmdImm(cmdImm), .cmdCond(cmdCond),
		.cmdAck(cmdAck), .result(result),
		.flagN(flagN), .flagC(flagC), .flagZ(flagZ), .flagV(flagV),
		.condTrue(condTrue)
	);

	always #5 CLK = ~CLK;

	task automatic reportMismatch(input string name, input logic [31:0] expVal,
			input logic [31:0] actVal);
		valueErrs++;
		$display("[ERROR] time %0t: %s expected %h, got %h", $time, name, expVal, actVal);
	endtask

	task automatic reportProtocol(input string what);
		protoErrs++;
		$display("Protocol error at time %0t: %s", $time, what);
	endtask

	// Jump condition table over the model flags
	function automatic logic condHolds(input cond_t c);
		case (c)
			UC: return 1'b1;
			P:  return !mN && !mZ;
			LS: return mC || mZ;
			HI: return !mC && !mZ;
			LT: return mN != mV;
			GE: return mN == mV;
			LE: return (mN != mV) || mZ;
			GT: return !mZ && (mN == mV);
			LO: return mC;
			HS: return !mC;
			EQ: return mZ;
			NE: return !mZ;
			V:  return mV;
			NV: return !mV;
			N:  return mN;
			NN: return !mN;
			default: return 1'b0;
		endcase
	endfunction

	task automatic predict(input opcode_t op, input logic [3:0] rd, input logic [3:0] rs,
			input logic [31:0] imm, input cond_t cond);
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] res;
		logic [32:0] wide;
		logic [4:0]  cnt;
		longint      exact;	// Signed result without wrap
		a = model[rd];
		b = model[rs];
		cnt = b[4:0];
		res = a;
		case (op)
			OP_MOVI: res = imm;
			OP_ADD: begin
				wide = {1'b0, a} + {1'b0, b};
				res = wide[31:0];
				exact = longint'($signed(a)) + longint'($signed(b));
				mC = wide[32];
				mV = exact != longint'($signed(res));
			end
			OP_SUB: begin
				res = a - b;
				exact = longint'($signed(a)) - longint'($signed(b));
				mC = a < b;	// Borrow
				mV = exact != longint'($signed(res));
			end
			OP_AND: res = a & b;
			OP_OR:  res = a | b;
			OP_XOR: res = a ^ b;
			OP_SLL: begin
				res = a << cnt;
				mC = (cnt == 5'd0) ? 1'b0 : a[5'd0 - cnt];	// Bit 32 - cnt
			end
			OP_SRL: begin
				res = a >> cnt;
				mC = (cnt == 5'd0) ? 1'b0 : a[cnt - 5'd1];
			end
			OP_SRA: begin
				res = $unsigned($signed(a) >>> cnt);
				mC = (cnt == 5'd0) ? 1'b0 : a[cnt - 5'd1];
			end
			OP_DIVU: if (b != 32'd0) res = a / b;
			default: ;
		endcase
		case (op)
			OP_JCC: ;
			OP_DIVU: begin
				mV = (b == 32'd0);
				if (b != 32'd0) begin
					mN = res[31];
					mZ = (res == 32'd0);
				end
			end
			default: begin
				if (op != OP_AND && op != OP_OR && op != OP_XOR) mN = res[31];
				mZ = (res == 32'd0);
				if (op != OP_ADD && op != OP_SUB) mV = 1'b0;
			end
		endcase
		if (op != OP_JCC) model[rd] = res;
		expResult = model[rd];
		{expN, expC, expZ, expV} = {mN, mC, mZ, mV};
		expCond = condHolds(cond);
	endtask

	// Full four-phase transfer with hold extra back-pressure cycles
	task automatic issue(input opcode_t op, input logic [3:0] rd, input logic [3:0] rs,
			input logic [31:0] imm, input cond_t cond, input int hold);
		predict(op, rd, rs, imm, cond);
		@(posedge CLK);
		cmdReq <= 1'b1;
		cmdOp <= op;
		cmdRd <= rd;
		cmdRs <= rs;
		cmdImm <= imm;
		cmdCond <= cond;
		do @(posedge CLK); while (!cmdAck);
		repeat (hold) @(posedge CLK);
		cmdReq <= 1'b0;
		do @(posedge CLK); while (cmdAck);
		cmdsDone++;
	endtask

	task automatic condSweep(input logic [3:0] rd);
		for (int c = 0; c < 16; c++) begin
			issue(OP_JCC, rd, 4'd0, 32'd0, cond_t'(c), c % 2);
		end
	endtask

	aResetAck: assert property (@(posedge CLK) !RST_N |-> !cmdAck)
		else reportProtocol("cmdAck high during reset");
	// Ack registered on the second edge and seen on the third
	aLatency: assert property (@(posedge CLK) disable iff (!RST_N)
		$rose(cmdAck) && cmdOp != OP_DIVU |-> $past(cmdReq, 3) && !$past(cmdReq, 4))
		else reportProtocol("cmdAck did not rise two cycles after the request was taken");
	aHold: assert property (@(posedge CLK) disable iff (!RST_N)
		cmdAck && cmdReq |=> cmdAck && $stable(result) && $stable(condTrue)
			&& $stable({flagN, flagC, flagZ, flagV}))
		else reportProtocol("ack or outputs changed while the host held cmdReq");
	aRelease: assert property (@(posedge CLK) disable iff (!RST_N)
		cmdAck && !cmdReq |=> !cmdAck)
		else reportProtocol("cmdAck stayed high after cmdReq dropped");
	aResult: assert property (@(posedge CLK) disable iff (!RST_N)
		$rose(cmdAck) |-> result == expResult)
		else reportMismatch("result", expResult, $sampled(result));
	aFlagN: assert property (@(posedge CLK) disable iff (!RST_N)
		$rose(cmdAck) |-> flagN == expN)
		else reportMismatch("flagN", 32'(expN), 32'($sampled(flagN)));
	aFlagC: assert property (@(posedge CLK) disable iff (!RST_N)
		$rose(cmdAck) |-> flagC == expC)
		else reportMismatch("flagC", 32'(expC), 32'($sampled(flagC)));
	aFlagZ: assert property (@(posedge CLK) disable iff (!RST_N)
		$rose(cmdAck) |-> flagZ == expZ)
		else reportMismatch("flagZ", 32'(expZ), 32'($sampled(flagZ)));
	aFlagV: assert property (@(posedge CLK) disable iff (!RST_N)
		$rose(cmdAck) |-> flagV == expV)
		else reportMismatch("flagV", 32'(expV), 32'($sampled(flagV)));
	aCond: assert property (@(posedge CLK) disable iff (!RST_N)
		$rose(cmdAck) |-> condTrue == expCond)
		else reportMismatch("condTrue", 32'(expCond), 32'($sampled(condTrue)));

	initial begin
		repeat (WatchdogCycles) @(posedge CLK);
		$display("Timeout after %0d cycles with %0d commands done", WatchdogCycles, cmdsDone);
		$display("Something failed");
		$finish;
	end

	initial begin : stimulus
		logic [31:0] rv;
		logic [31:0] imm;
		CLK = 1'b0;
		RST_N = 1'b0;
		cmdReq = 1'b0;
		cmdOp = OP_MOVI;
		cmdRd = 4'd0;
		cmdRs = 4'd0;
		cmdImm = 32'd0;
		cmdCond = UC;
		valueErrs = 0;
		protoErrs = 0;
		cmdsDone = 0;
		seed = 32'hba51625a;
		for (int r = 0; r < 16; r++) model[r] = 32'd0;
		{mN, mC, mZ, mV} = 4'b0000;
		repeat (4) @(posedge CLK);
		RST_N <= 1'b1;
		repeat (2) @(posedge CLK);

		issue(OP_MOVI, 4'd1, 4'd0, 32'h7fffffff, UC, 0);
		issue(OP_MOVI, 4'd2, 4'd0, 32'h00000001, P, 0);
		issue(OP_ADD, 4'd1, 4'd2, 32'd0, V, 3);	// Signed overflow
		issue(OP_MOVI, 4'd3, 4'd0, 32'hffffffff, N, 0);
		issue(OP_ADD, 4'd3, 4'd2, 32'd0, EQ, 0);	// Carry out, zero
		issue(OP_MOVI, 4'd4, 4'd0, 32'd5, UC, 0);
		issue(OP_MOVI, 4'd5, 4'd0, 32'd7, UC, 1);
		issue(OP_SUB, 4'd4, 4'd5, 32'd0, LO, 0);	// Borrow
		issue(OP_MOVI, 4'd6, 4'd0, 32'h80000000, NN, 0);
		issue(OP_SUB, 4'd6, 4'd2, 32'd0, V, 2);
		issue(OP_SUB, 4'd13, 4'd2, 32'd0, LO, 0);	// Borrow kept through logic ops
		issue(OP_AND, 4'd1, 4'd3, 32'd0, EQ, 0);
		issue(OP_MOVI, 4'd7, 4'd0, 32'hf0f0f0f0, UC, 0);
		issue(OP_MOVI, 4'd8, 4'd0, 32'h0ff00ff0, UC, 0);
		issue(OP_OR, 4'd7, 4'd8, 32'd0, NE, 0);
		issue(OP_XOR, 4'd7, 4'd8, 32'd0, GT, 0);
		issue(OP_MOVI, 4'd9, 4'd0, 32'd0, UC, 0);
		issue(OP_SLL, 4'd7, 4'd9, 32'd0, HS, 0);	// Count 0 clears C
		issue(OP_MOVI, 4'd9, 4'd0, 32'd4, UC, 0);
		issue(OP_SLL, 4'd7, 4'd9, 32'd0, LO, 0);
		issue(OP_SRL, 4'd7, 4'd9, 32'd0, LS, 0);
		issue(OP_MOVI, 4'd10, 4'd0, 32'h80000018, N, 0);
		issue(OP_SRA, 4'd10, 4'd9, 32'd0, LT, 1);
		issue(OP_MOVI, 4'd11, 4'd0, 32'd100, UC, 0);
		issue(OP_MOVI, 4'd12, 4'd0, 32'd7, UC, 0);
		issue(OP_DIVU, 4'd11, 4'd12, 32'd0, EQ, 0);
		issue(OP_DIVU, 4'd11, 4'd0, 32'd0, V, 2);	// Zero divisor
		condSweep(4'd11);
		issue(OP_SUB, 4'd2, 4'd2, 32'd0, EQ, 0);
		condSweep(4'd2);

		for (int i = 0; i < NumRandom; i++) begin
			rv = $random(seed);
			imm = $random(seed);
			if (rv[20:18] == 3'd0) imm = {27'd0, imm[4:0]};	// Small counts and zeros
			issue(opcode_t'(rv[3:0] % 4'd11), rv[7:4], rv[11:8], imm,
				cond_t'(rv[15:12]), int'(rv[17:16]));
		end

		repeat (2) @(posedge CLK);
		$display("Done: %0d commands, %0d value errors, %0d protocol errors",
			cmdsDone, valueErrs, protoErrs);
		if (valueErrs == 0 && protoErrs == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule
